//--- sources.f
+incdir+.
aib_cfg_pkg.sv
spi_bit_counter.sv
spi_shifter.sv
spi_frame_fsm.sv
cfg_reg_file.sv
aib_spi_cfg_top.sv
tb_aib_spi_cfg.sv

//--- Makefile
# Verilator flow for the AIB SPI configuration port

VERILATOR ?= verilator
FILELIST  ?= sources.f
TOP       ?= tb_aib_spi_cfg
RTL_TOP   ?= aib_spi_cfg_top
BUILD_DIR ?= obj_dir
SIM_BIN   ?= sim_$(TOP)
LOG       ?= sim.log
TIMESCALE ?= 1ns/1ns
VFLAGS    ?= --timing --assert --timescale $(TIMESCALE)
FAIL_MSG  := Test failures found
PASS_MSG  := All tests passed!

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o $(SIM_BIN)

sim: build
	./$(BUILD_DIR)/$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation incomplete"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb_aib_spi_cfg.sv
// ----------------------------------------
// AIB SPI config port testbench
// ----------------------------------------

`default_nettype none

`include "aib_cfg_params.svh"

module tb_aib_spi_cfg
    import aib_cfg_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ns;

    // SPI half period in system clocks
    localparam int half_clks  = 8;
    localparam int frame_bits = `AIB_CFG_FRAME_BITS;
    localparam int hdr_bits   = `AIB_CFG_HDR_BITS;
    localparam int reg_num    = `AIB_CFG_REG_NUM;
    localparam int idx_w      = $clog2(reg_num);
    localparam int n_abort    = 10;
    localparam int n_random   = 200;
    // Frame count summed over the five tests
    localparam int n_frames   = 128 + 2 * reg_num + 2 * 112 + 3 * n_abort + n_random;
    // Select setup and gaps add about 64 cycles per frame
    localparam int max_cycles = n_frames * frame_bits * 2 * half_clks + n_frames * 64 + 2000;

    // One finished frame waiting for comparison
    typedef struct packed {
        logic      chk_miso;
        cfg_word_t exp_miso;
        cfg_word_t got_miso;
        cfg_bank_t exp_bank;
    } check_t;

    logic        dut_slave1 = 1'b0;
    logic        rst_n;
    logic        sclk;
    logic        ss_n;
    logic        mosi;
    logic        miso;
    cfg_bank_t   cfg_out;
    cfg_bank_t   shadow;
    check_t      check_q[$];
    int          errors;
    int          checks;
    int          cycles;
    int          test_errs;

    always #50 dut_slave1 = ~dut_slave1;

    aib_spi_cfg_top DUT (
        .dut_slave1 (dut_slave1),
        .rst_n      (rst_n),
        .sclk       (sclk),
        .ss_n       (ss_n),
        .mosi       (mosi),
        .miso       (miso),
        .cfg_out    (cfg_out)
    );

    // ----------------------------------------
    // Reference model
    // ----------------------------------------

    // Applies one frame to the shadow bank and returns the word seen on miso
    function automatic cfg_word_t ref_frame(input logic wr, input logic [6:0] addr,
                                            input cfg_word_t data, input logic complete);
        cfg_word_t stored;
        logic      in_range;
        in_range = (addr < 7'(reg_num));
        stored   = in_range ? shadow[addr[idx_w-1:0]] : 32'h0;
        // Only a finished write frame to a real register changes the bank
        if (wr && complete && in_range) begin
            shadow[addr[idx_w-1:0]] = data;
        end
        // Miso stays low through a write
        return wr ? 32'h0 : stored;
    endfunction

    // ----------------------------------------
    // SPI master
    // ----------------------------------------

    // Mode 0 frame that is cut short when nbits is below the frame length
    task automatic spi_frame(input logic wr, input logic [6:0] addr, input cfg_word_t data,
                             input int nbits, output cfg_word_t got);
        logic [39:0] bits;
        int          i;
        bits = {wr, addr, data};
        got  = '0;
        @(posedge dut_slave1);
        ss_n <= 1'b0;
        for (i = 0; i < nbits; i++) begin
            // Mosi changes while sclk is low
            @(posedge dut_slave1);
            sclk <= 1'b0;
            mosi <= bits[frame_bits-1-i];
            repeat (half_clks - 1) @(posedge dut_slave1);
            // Miso is stable half a clock before the SPI rising edge
            @(negedge dut_slave1);
            if (i >= hdr_bits) begin
                got[frame_bits-1-i] = miso;
            end
            @(posedge dut_slave1);
            sclk <= 1'b1;
            repeat (half_clks - 1) @(posedge dut_slave1);
        end
        @(posedge dut_slave1);
        sclk <= 1'b0;
        repeat (half_clks) @(posedge dut_slave1);
        ss_n <= 1'b1;
        mosi <= 1'b0;
        repeat (half_clks) @(posedge dut_slave1);
    endtask

    // Sends a frame and queues the expected bank and miso word
    task automatic run_frame(input logic wr, input logic [6:0] addr, input cfg_word_t data,
                             input int nbits);
        cfg_word_t got;
        check_t    rec;
        logic      complete;
        complete = (nbits == frame_bits);
        spi_frame(wr, addr, data, nbits, got);
        rec.exp_miso = ref_frame(wr, addr, data, complete);
        rec.chk_miso = complete;
        rec.got_miso = got;
        rec.exp_bank = shadow;
        check_q.push_back(rec);
    endtask

    // Waits for the compare process and then reports the test
    task automatic end_test(input int num, input string name);
        while (check_q.size() != 0) @(posedge dut_slave1);
        @(posedge dut_slave1);
        if (errors == test_errs) begin
            $display("Test %0d %s: ok", num, name);
        end else begin
            $display("Test %0d %s: FAILED with %0d errors", num, name, errors - test_errs);
        end
        test_errs = errors;
    endtask

    // ----------------------------------------
    // Compare process
    // ----------------------------------------

    always @(negedge dut_slave1) begin : compare
        check_t rec;
        int     w;
        if (check_q.size() > 0) begin
            rec = check_q.pop_front();
            for (w = 0; w < reg_num; w++) begin
                checks++;
                assert (cfg_out[w] == rec.exp_bank[w]) else begin
                    errors++;
                    $display("Fail at time %0t: cfg_out[%0d] expected %h, got %h",
                             $time, w, rec.exp_bank[w], cfg_out[w]);
                end
            end
            if (rec.chk_miso) begin
                checks++;
                assert (rec.got_miso == rec.exp_miso) else begin
                    errors++;
                    $display("Fail at time %0t: miso word expected %h, got %h",
                             $time, rec.exp_miso, rec.got_miso);
                end
            end
        end
    end

    // Run length guard
    always @(posedge dut_slave1) begin
        cycles++;
        if (cycles > max_cycles) begin
            $display("Timeout: the run did not end within %0d cycles", max_cycles);
            $display("Test failures found");
            $finish;
        end
    end

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------

    initial begin : main
        cfg_word_t  tmp;
        int         i;
        int         nb;
        logic       wr;
        logic [6:0] addr;
        rst_n     = 1'b0;
        sclk      = 1'b0;
        ss_n      = 1'b1;
        mosi      = 1'b0;
        errors    = 0;
        checks    = 0;
        cycles    = 0;
        test_errs = 0;
        shadow    = '0;
        void'($urandom(32'h3d59_e76d));
        repeat (8) @(posedge dut_slave1);
        rst_n <= 1'b1;
        repeat (4) @(posedge dut_slave1);

        // Whole address space reads zero out of reset
        for (i = 0; i < 128; i++) begin
            run_frame(1'b0, 7'(i), $urandom, frame_bits);
        end
        end_test(1, "reset values");

        // Low nibble keeps the values distinct
        for (i = 0; i < reg_num; i++) begin
            tmp = $urandom;
            run_frame(1'b1, 7'(i), {tmp[31:4], 4'(i)}, frame_bits);
        end
        for (i = 0; i < reg_num; i++) begin
            run_frame(1'b0, 7'(i), $urandom, frame_bits);
        end
        end_test(2, "write and read back");

        // Unimplemented space
        for (i = reg_num; i < 128; i++) begin
            run_frame(1'b1, 7'(i), $urandom, frame_bits);
        end
        for (i = reg_num; i < 128; i++) begin
            run_frame(1'b0, 7'(i), $urandom, frame_bits);
        end
        end_test(3, "out of range access");

        // Cut write followed by a full write and a read of the same word
        for (i = 0; i < n_abort; i++) begin
            nb   = int'($urandom_range(1, frame_bits - 1));
            addr = 7'($urandom_range(0, reg_num - 1));
            run_frame(1'b1, addr, $urandom, nb);
            run_frame(1'b1, addr, $urandom, frame_bits);
            run_frame(1'b0, addr, $urandom, frame_bits);
        end
        end_test(4, "aborted frames");

        // Mostly implemented addresses with some beyond
        for (i = 0; i < n_random; i++) begin
            wr   = 1'($urandom_range(0, 1));
            addr = 7'($urandom_range(0, reg_num + 7));
            run_frame(wr, addr, $urandom, frame_bits);
        end
        end_test(5, "random frames");

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- aib_spi_cfg_top.sv
// ----------------------------------------
// AIB SPI configuration port
// ----------------------------------------

`default_nettype none

`include "aib_cfg_params.svh"

module aib_spi_cfg_top
    import aib_cfg_pkg::*;
(
    input  logic      dut_slave1,
    input  logic      rst_n,
    input  logic      sclk,
    input  logic      ss_n,
    input  logic      mosi,
    output logic      miso,
    output cfg_bank_t cfg_out
);

    // Edge pulses and frame status
    logic      sclk_rise;
    logic      frame_active;
    logic      header_done;
    logic      frame_done;
    logic      mosi_s;
    // Shifter strobes
    logic      rx_cmd_shift;
    logic      rx_data_shift;
    logic      tx_load;
    logic      tx_shift;
    logic      tx_active;
    logic      tx_dout;
    // Payloads and bank access
    spi_cmd_t  cmd;
    cfg_word_t wdata;
    cfg_word_t rdata;
    cfg_req_t  req;

    // ----------------------------------------
    // Frame control
    // ----------------------------------------

    // Falling edges are only used inside the FSM
    spi_frame_fsm u_fsm (
        .dut_slave1    (dut_slave1),
        .rst_n         (rst_n),
        .sclk          (sclk),
        .ss_n          (ss_n),
        .mosi          (mosi),
        .header_done   (header_done),
        .frame_done    (frame_done),
        .cmd           (cmd),
        .wdata         (wdata),
        .sclk_rise     (sclk_rise),
        .sclk_fall     (),
        .frame_active  (frame_active),
        .mosi_s        (mosi_s),
        .rx_cmd_shift  (rx_cmd_shift),
        .rx_data_shift (rx_data_shift),
        .tx_load       (tx_load),
        .tx_shift      (tx_shift),
        .tx_active     (tx_active),
        .req           (req)
    );

    spi_bit_counter u_cnt (
        .dut_slave1   (dut_slave1),
        .rst_n        (rst_n),
        .sclk_rise    (sclk_rise),
        .frame_active (frame_active),
        .header_done  (header_done),
        .frame_done   (frame_done)
    );

    // ----------------------------------------
    // Shifters and register bank
    // ----------------------------------------

    // Header in, never loaded
    spi_shifter #(.payload_t(spi_cmd_t)) rx_cmd (
        .dut_slave1 (dut_slave1),
        .rst_n      (rst_n),
        .shift      (rx_cmd_shift),
        .din        (mosi_s),
        .load       (1'b0),
        .load_val   ('0),
        .value      (cmd),
        .dout       ()
    );

    // Write data in
    spi_shifter #(.payload_t(cfg_word_t)) rx_data (
        .dut_slave1 (dut_slave1),
        .rst_n      (rst_n),
        .shift      (rx_data_shift),
        .din        (mosi_s),
        .load       (1'b0),
        .load_val   ('0),
        .value      (wdata),
        .dout       ()
    );

    // Read data out, zeros fill from the bottom
    spi_shifter #(.payload_t(cfg_word_t)) tx_data (
        .dut_slave1 (dut_slave1),
        .rst_n      (rst_n),
        .shift      (tx_shift),
        .din        (1'b0),
        .load       (tx_load),
        .load_val   (rdata),
        .value      (),
        .dout       (tx_dout)
    );

    cfg_reg_file u_regs (
        .dut_slave1 (dut_slave1),
        .rst_n      (rst_n),
        .req        (req),
        .rdata      (rdata),
        .cfg_out    (cfg_out)
    );

    // Low outside the read data phase
    assign miso = tx_dout & tx_active;

endmodule

`default_nettype wire

//--- cfg_reg_file.sv
// ----------------------------------------
// Channel configuration register bank
// ----------------------------------------

`default_nettype none

`include "aib_cfg_params.svh"

module cfg_reg_file
    import aib_cfg_pkg::*;
(
    input  logic      dut_slave1,
    input  logic      rst_n,
    input  cfg_req_t  req,
    output cfg_word_t rdata,
    output cfg_bank_t cfg_out
);

    // Index bits that select a register
    localparam int idx_w = $clog2(`AIB_CFG_REG_NUM);

    cfg_bank_t        regs;
    logic [idx_w-1:0] idx;
    logic             addr_ok;

    // ----------------------------------------
    // Address decode
    // ----------------------------------------

    // Low bits pick the word
    assign idx = req.addr[idx_w-1:0];

    // Upper address bits must be zero for an implemented register
    assign addr_ok = (req.addr[`AIB_CFG_ADDR_W-1:idx_w] == '0);

    // ----------------------------------------
    // Write port
    // ----------------------------------------

    always_ff @(posedge dut_slave1) begin
        if (!rst_n) begin
            // Channels come up unprogrammed
            regs <= '0;
        end else if (req.wr && addr_ok) begin
            regs[idx] <= req.wdata;
        end
        // Out of range writes fall through
    end

    // ----------------------------------------
    // Read port
    // ----------------------------------------

    // Registered, valid the cycle after rd
    always_ff @(posedge dut_slave1) begin
        if (req.rd) begin
            if (addr_ok) begin
                rdata <= regs[idx];
            end else begin
                // Unimplemented space reads as zero
                rdata <= '0;
            end
        end
    end

    // Whole bank straight to the channel config bus
    assign cfg_out = regs;

endmodule

`default_nettype wire

//--- spi_frame_fsm.sv
// ----------------------------------------
// SPI pin sampling and frame FSM
// ----------------------------------------

`default_nettype none

`include "aib_cfg_params.svh"

module spi_frame_fsm
    import aib_cfg_pkg::*;
(
    input  logic      dut_slave1,
    input  logic      rst_n,
    input  logic      sclk,
    input  logic      ss_n,
    input  logic      mosi,
    input  logic      header_done,
    input  logic      frame_done,
    input  spi_cmd_t  cmd,
    input  cfg_word_t wdata,
    output logic      sclk_rise,
    output logic      sclk_fall,
    output logic      frame_active,
    output logic      mosi_s,
    output logic      rx_cmd_shift,
    output logic      rx_data_shift,
    output logic      tx_load,
    output logic      tx_shift,
    output logic      tx_active,
    output cfg_req_t  req
);

    localparam int sync_n = `AIB_CFG_SYNC_STAGES;

    logic [sync_n-1:0] sclk_sync;
    logic [sync_n-1:0] ss_n_sync;
    logic [sync_n-1:0] mosi_sync;
    logic              sclk_q;
    logic              ss_n_s;
    frame_state_t      state;
    frame_state_t      state_nxt;
    logic              is_read;
    logic              wr_q;
    logic              rd_q;
    logic              tx_armed;

    // ----------------------------------------
    // Pin synchronizers and edge detect
    // ----------------------------------------

    // All three pins share one delay so mosi lines up with the edge pulse
    always_ff @(posedge dut_slave1) begin
        if (!rst_n) begin
            sclk_sync <= '0;
            ss_n_sync <= '1;
            mosi_sync <= '0;
            sclk_q    <= 1'b0;
            sclk_rise <= 1'b0;
            sclk_fall <= 1'b0;
            ss_n_s    <= 1'b1;
            mosi_s    <= 1'b0;
        end else begin
            sclk_sync <= {sclk_sync[sync_n-2:0], sclk};
            ss_n_sync <= {ss_n_sync[sync_n-2:0], ss_n};
            mosi_sync <= {mosi_sync[sync_n-2:0], mosi};
            sclk_q    <= sclk_sync[sync_n-1];
            // Edge register is the third stage after the pin
            sclk_rise <= sclk_sync[sync_n-1] & ~sclk_q;
            sclk_fall <= ~sclk_sync[sync_n-1] & sclk_q;
            ss_n_s    <= ss_n_sync[sync_n-1];
            mosi_s    <= mosi_sync[sync_n-1];
        end
    end

    // ----------------------------------------
    // Frame sequencing
    // ----------------------------------------

    always_ff @(posedge dut_slave1) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle:   if (!ss_n_s) state_nxt = st_header;
            st_header: if (header_done) state_nxt = st_access;
            // Access lasts exactly one cycle
            st_access: state_nxt = st_data;
            st_data:   if (frame_done) state_nxt = st_done;
            // Extra bits are ignored here until deselect
            st_done:   state_nxt = st_done;
            default:   state_nxt = st_idle;
        endcase
        // Deselect ends any frame, an unfinished one is dropped
        if (ss_n_s) begin
            state_nxt = st_idle;
        end
    end

    assign is_read      = ~cmd.wr;
    assign frame_active = (state != st_idle);

    // Receive strobes per phase
    assign rx_cmd_shift  = sclk_rise && (state == st_header);
    assign rx_data_shift = sclk_rise && (state == st_data);

    // ----------------------------------------
    // Register requests and read return
    // ----------------------------------------

    always_ff @(posedge dut_slave1) begin
        if (!rst_n) begin
            wr_q     <= 1'b0;
            rd_q     <= 1'b0;
            tx_armed <= 1'b0;
        end else begin
            // Write fires only once the 40th bit is in
            wr_q     <= frame_done && (state == st_data) && cmd.wr;
            // Read word is back from the bank one cycle after rd
            rd_q     <= req.rd;
            // Bit 31 already sits on miso for the first data edge
            tx_armed <= (state == st_data) && (tx_armed || sclk_rise);
        end
    end

    always_comb begin
        req       = '0;
        req.wr    = wr_q;
        req.rd    = (state == st_access) && is_read;
        req.addr  = cmd.addr;
        req.wdata = wdata;
    end

    // Miso valid only in the data phase of a read
    assign tx_active = (state == st_data) && is_read;
    assign tx_load   = rd_q;
    assign tx_shift  = sclk_fall && tx_active && tx_armed;

    // One frame gives either a read or a write, never both at once
    a_wr_rd_excl: assert property (
        @(posedge dut_slave1) disable iff (!rst_n)
        !(req.wr && req.rd)
    ) else $error("wr and rd requested together");

endmodule

`default_nettype wire

//--- spi_shifter.sv
// ----------------------------------------
// Serial payload shift register
// ----------------------------------------

`default_nettype none

module spi_shifter
    import aib_cfg_pkg::*;
#(
    // Payload carried by this instance, struct or plain vector
    parameter type payload_t = cfg_word_t
) (
    input  logic     dut_slave1,
    input  logic     rst_n,
    input  logic     shift,
    input  logic     din,
    input  logic     load,
    input  payload_t load_val,
    output payload_t value,
    output logic     dout
);

    localparam int width = $bits(payload_t);

    // Flat view of the payload, MSB leaves first
    logic [width-1:0] bits_q;

    // ----------------------------------------
    // Shift and parallel load
    // ----------------------------------------

    always_ff @(posedge dut_slave1) begin
        if (!rst_n) begin
            bits_q <= '0;
        end else if (load) begin
            // Parallel load of a whole word
            bits_q <= load_val;
        end else if (shift) begin
            // MSB first, new bit enters at the LSB
            bits_q <= {bits_q[width-2:0], din};
        end
    end

    // Struct view back for the consumer
    assign value = payload_t'(bits_q);

    // Bit currently on the wire
    assign dout = bits_q[width-1];

    // Load and shift come from different SPI phases
    a_no_shift_load: assert property (
        @(posedge dut_slave1) disable iff (!rst_n)
        !(shift && load)
    ) else $error("shift and load in the same cycle");

endmodule

`default_nettype wire

//--- spi_bit_counter.sv
// ----------------------------------------
// SPI frame bit counter
// ----------------------------------------

`default_nettype none

`include "aib_cfg_params.svh"

module spi_bit_counter (
    input  logic dut_slave1,
    input  logic rst_n,
    input  logic sclk_rise,
    input  logic frame_active,
    output logic header_done,
    output logic frame_done
);

    // Count value seen on the edge that completes the header
    localparam logic [5:0] hdr_last = 6'(`AIB_CFG_HDR_BITS - 1);
    // Saturation point, edges past this are ignored
    localparam logic [5:0] frame_bits = 6'(`AIB_CFG_FRAME_BITS);

    logic [5:0] count;
    logic       count_en;

    // Only edges inside a frame and below saturation are counted
    assign count_en = frame_active && sclk_rise && (count < frame_bits);

    // ----------------------------------------
    // Edge count
    // ----------------------------------------

    always_ff @(posedge dut_slave1) begin
        if (!rst_n || !frame_active) begin
            // Leaving the frame, aborted or not, restarts the count
            count <= '0;
        end else if (count_en) begin
            count <= count + 6'd1;
        end
    end

    // Strobes coincide with the edge that brings in the last bit
    assign header_done = count_en && (count == hdr_last);
    assign frame_done  = count_en && (count == frame_bits - 6'd1);

    // Count stays within one frame however many edges arrive
    a_count_sat: assert property (
        @(posedge dut_slave1) disable iff (!rst_n)
        count <= frame_bits
    ) else $error("bit count above frame length");

endmodule

`default_nettype wire

//--- aib_cfg_pkg.sv
// ----------------------------------------
// AIB config port types
// ----------------------------------------

`default_nettype none

`include "aib_cfg_params.svh"

package aib_cfg_pkg;

    // ----------------------------------------
    // SPI frame fields
    // ----------------------------------------

    // First bit on the wire is wr, then the address MSB first
    typedef struct packed {
        logic                       wr;
        logic [`AIB_CFG_ADDR_W-1:0] addr;
    } spi_cmd_t;

    typedef logic [`AIB_CFG_DATA_W-1:0] cfg_word_t;

    // ----------------------------------------
    // Register bank side
    // ----------------------------------------

    // Single-cycle access, wr and rd are exclusive
    typedef struct packed {
        logic                       wr;
        logic                       rd;
        logic [`AIB_CFG_ADDR_W-1:0] addr;
        cfg_word_t                  wdata;
    } cfg_req_t;

    // Word 0 sits in the low bits of the bus
    typedef cfg_word_t [`AIB_CFG_REG_NUM-1:0] cfg_bank_t;

    // Frame sequencing
    typedef enum logic [2:0] {
        st_idle,
        st_header,
        st_access,
        st_data,
        st_done
    } frame_state_t;

endpackage

`default_nettype wire

//--- aib_cfg_params.svh
// ----------------------------------------
// AIB config port widths and depths
// ----------------------------------------

`ifndef AIB_CFG_PARAMS_SVH
`define AIB_CFG_PARAMS_SVH

// Address field of the SPI header
`define AIB_CFG_ADDR_W 7

// One configuration word
`define AIB_CFG_DATA_W 32

// Implemented channel registers, the rest of the address space reads 0
`define AIB_CFG_REG_NUM 16

// Header is the write flag plus the address
`define AIB_CFG_HDR_BITS 8

// Header plus one data word
`define AIB_CFG_FRAME_BITS 40

// Flops per asynchronous SPI pin
`define AIB_CFG_SYNC_STAGES 2

`endif
